// File: Makefile
# Verilator build and run of the ps/2 mouse testbench

TOP := tb_ps2_mouse_xy

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f list.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: cursor_tracker.sv
// --------------------------------------
// cursor tracker
// turns signed movement into a clamped absolute x/y position
// --------------------------------------
`timescale 1ns/1ps
`include "mouse_settings.svh"

module cursor_tracker #(
  parameter int max_x = `MOUSE_MAX_X,
  parameter int max_y = `MOUSE_MAX_Y
) (
  input  logic           clk,
  input  logic           reset,
  report_if.sink         rep,
  output mouse_pkg::pos_t mx,
  output mouse_pkg::pos_t my,
  output logic [2:0]     btn_click,
  output logic           move
);

  import mouse_pkg::*;

  logic [8:0] mag_x;
  logic [8:0] mag_y;

  // magnitude of a 9 bit two's complement delta, -256 gives 256
  function automatic logic [8:0] magnitude(input logic signed [8:0] d);
    return d[8] ? (~d + 9'd1) : d;
  endfunction

  // one step up with a ceiling at limit, or down with a floor at 0
  function automatic pos_t step_clamped(input pos_t pos, input logic [8:0] mag,
                                        input logic up, input pos_t limit);
    logic [`MOUSE_POS_BITS:0] sum;
    sum = {1'b0, pos} + mag;
    if (up)
      return (sum > limit) ? limit : sum[`MOUSE_POS_BITS-1:0];
    return (pos > mag) ? pos - mag : '0;
  endfunction

  assign mag_x = magnitude(rep.report.dx);
  assign mag_y = magnitude(rep.report.dy);

  // y counts downward on screen, so a positive dy moves the cursor up
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      mx        <= '0;
      my        <= '0;
      btn_click <= '0;
      move      <= 1'b0;
    end
    else
    begin
      move <= rep.valid;
      if (rep.valid)
      begin
        mx        <= step_clamped(mx, mag_x, !rep.report.dx[8], pos_t'(max_x));
        my        <= step_clamped(my, mag_y, rep.report.dy[8], pos_t'(max_y));
        btn_click <= {rep.report.left, rep.report.middle, rep.report.right};
      end
    end
  end

endmodule

// File: list.f
+incdir+.
mouse_pkg.sv
mouse_ifs.sv
ps2_line_filter.sv
ps2_bit_shifter.sv
mouse_rx_control.sv
mouse_packet_decoder.sv
cursor_tracker.sv
ps2_mouse_xy.sv
tb_ps2_mouse_xy.sv

// File: mouse_ifs.sv
// --------------------------------------
// mouse receive path interfaces
// --------------------------------------
`timescale 1ns/1ps

// raw bits from the shifter, seen by the control FSM and the decoder
interface rx_bits_if;
  import mouse_pkg::*;

  ps2_packet_t packet;
  bit_count_t  bit_count;
  logic        gap_timeout;
  logic        load;

  modport shifter (output packet, output bit_count, output gap_timeout);
  modport control (input bit_count, input gap_timeout, output load);
  modport decoder (input packet, input load);
endinterface

// decoded report from the decoder to the cursor tracker
interface report_if;
  import mouse_pkg::*;

  mouse_report_t report;
  logic          valid;

  modport source (output report, output valid);
  modport sink (input report, input valid);
endinterface

// File: mouse_packet_decoder.sv
// --------------------------------------
// mouse packet decoder
// checks framing and parity, registers buttons and deltas
// --------------------------------------
`timescale 1ns/1ps

module mouse_packet_decoder (
  input  logic       clk,
  input  logic       reset,
  rx_bits_if.decoder rx,
  output logic       packet_good,
  report_if.source   rep
);

  import mouse_pkg::*;

  ps2_packet_t           pkt;
  logic [ps2_frames-1:0] frame_ok;
  mouse_report_t         report_q;
  logic                  valid_q;

  assign pkt = rx.packet;

  // each frame needs a low start bit, a high stop bit and odd parity
  // over the data byte together with its parity bit
  always_comb
  begin
    for (int i = 0; i < ps2_frames; i++)
    begin
      frame_ok[i] = !pkt[i].start && pkt[i].stop && (^{pkt[i].data, pkt[i].parity});
    end
  end

  assign packet_good = &frame_ok;

  // status byte layout is yv, xv, ys, xs, 1, m, r, l
  // the overflow bits are not used
  always_ff @(posedge clk)
  begin
    if (rx.load)
    begin
      report_q.left   <= pkt[0].data[0];
      report_q.right  <= pkt[0].data[1];
      report_q.middle <= pkt[0].data[2];
      report_q.dx     <= {pkt[0].data[4], pkt[1].data};
      report_q.dy     <= {pkt[0].data[5], pkt[2].data};
    end
  end

  // valid follows load by one cycle
  always_ff @(posedge clk)
  begin
    if (reset)
      valid_q <= 1'b0;
    else
      valid_q <= rx.load;
  end

  assign rep.report = report_q;
  assign rep.valid  = valid_q;

endmodule

// File: mouse_pkg.sv
// --------------------------------------
// ps/2 mouse package
// frame, packet and report types
// --------------------------------------
`include "mouse_settings.svh"

package mouse_pkg;

  // one serial frame as it sits in the shift register
  // the start bit arrives first and so ends up in the lsb
  typedef struct packed {
    logic       stop;
    logic       parity;
    logic [7:0] data;
    logic       start;
  } ps2_frame_t;

  // number of frames in one movement packet
  localparam int ps2_frames = `PS2_PACKET_BITS / $bits(ps2_frame_t);

  // frame 0 is the status byte, frame 1 is x and frame 2 is y
  typedef ps2_frame_t [ps2_frames-1:0] ps2_packet_t;

  // decoded packet handed to the cursor tracker
  // dx and dy take their sign bit from the status byte
  typedef struct packed {
    logic              left;
    logic              middle;
    logic              right;
    logic signed [8:0] dx;
    logic signed [8:0] dy;
  } mouse_report_t;

  // receive FSM states
  typedef enum logic [1:0] {
    rx_idle,
    rx_gather,
    rx_verify,
    rx_use
  } rx_state_t;

  typedef logic [`MOUSE_POS_BITS-1:0] pos_t;
  typedef logic [5:0] bit_count_t;

endpackage

// File: mouse_rx_control.sv
// --------------------------------------
// mouse receive control
// decides when a packet is complete and whether to accept it
// --------------------------------------
`timescale 1ns/1ps
`include "mouse_settings.svh"

module mouse_rx_control (
  input  logic       clk,
  input  logic       reset,
  input  logic       fall_pulse,
  input  logic       packet_good,
  rx_bits_if.control rx
);

  import mouse_pkg::*;

  localparam bit_count_t full_count = bit_count_t'(`PS2_PACKET_BITS);

  rx_state_t state;
  rx_state_t state_next;

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= rx_idle;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      // the first falling edge starts a packet
      rx_idle:
        if (fall_pulse)
          state_next = rx_gather;
      // the watchdog marks the end of the burst
      // the count is still valid in the expiry cycle
      rx_gather:
        if (rx.gap_timeout)
          state_next = (rx.bit_count == full_count) ? rx_verify : rx_idle;
      // framing and parity of all three frames decide
      rx_verify:
        state_next = packet_good ? rx_use : rx_idle;
      rx_use:
        state_next = rx_idle;
      default:
        state_next = rx_idle;
    endcase
  end

  // one cycle load, two cycles after the watchdog fires
  assign rx.load = (state == rx_use);

endmodule

// File: mouse_settings.svh
// --------------------------------------
// ps/2 mouse front end settings
// cursor range, widths and timer lengths
// --------------------------------------
`ifndef MOUSE_SETTINGS_SVH
`define MOUSE_SETTINGS_SVH

// clamp limits of the absolute cursor, in pixels
`define MOUSE_MAX_X 640
`define MOUSE_MAX_Y 480

// width of the x and y position registers
`define MOUSE_POS_BITS 12

// one movement packet is three frames of 11 bits
`define PS2_PACKET_BITS 33

// hold time after each clean clock edge, in clk cycles
// kept short so a simulation run stays quick
`define PS2_DEBOUNCE_CYCLES 4

// idle time on the ps/2 clock that ends a packet
// must be longer than the gap between bytes and shorter than the gap between packets
`define PS2_GAP_CYCLES 64

`endif

// File: ps2_bit_shifter.sv
// --------------------------------------
// ps/2 bit shifter
// collects serial bits into a packet, counts them and watches the gap
// --------------------------------------
`timescale 1ns/1ps
`include "mouse_settings.svh"

module ps2_bit_shifter (
  input  logic       clk,
  input  logic       reset,
  input  logic       fall_pulse,
  input  logic       rise_pulse,
  input  logic       data_sync,
  rx_bits_if.shifter rx
);

  import mouse_pkg::*;

  localparam int gap_bits = $clog2(`PS2_GAP_CYCLES + 1);

  logic [`PS2_PACKET_BITS-1:0] shift_q;
  bit_count_t                  count_q;
  logic [gap_bits-1:0]         gap_count;
  logic                        gap_done;

  // data is sampled on the falling clock edge and enters at the msb
  // after a full packet the first bit received sits in bit 0
  always_ff @(posedge clk)
  begin
    if (fall_pulse)
      shift_q <= {data_sync, shift_q[`PS2_PACKET_BITS-1:1]};
  end

  // an edge wins over the watchdog, the count clears one cycle after expiry
  // so a short or broken burst never runs into the next packet
  always_ff @(posedge clk)
  begin
    if (reset)
      count_q <= '0;
    else if (fall_pulse)
      count_q <= count_q + 1'b1;
    else if (gap_done)
      count_q <= '0;
  end

  // watchdog restarts on any edge and stops at its terminal count
  always_ff @(posedge clk)
  begin
    if (reset || fall_pulse || rise_pulse)
      gap_count <= '0;
    else if (!gap_done)
      gap_count <= gap_count + 1'b1;
  end

  assign gap_done = (gap_count == gap_bits'(`PS2_GAP_CYCLES - 1));

  assign rx.packet      = shift_q;
  assign rx.bit_count   = count_q;
  assign rx.gap_timeout = gap_done;

endmodule

// File: ps2_line_filter.sv
// --------------------------------------
// ps/2 line filter
// synchronizes both lines and turns clean clock edges into pulses
// --------------------------------------
`timescale 1ns/1ps
`include "mouse_settings.svh"

module ps2_line_filter (
  input  logic clk,
  input  logic reset,
  input  logic ps2_clk,
  input  logic ps2_data,
  output logic fall_pulse,
  output logic rise_pulse,
  output logic data_sync
);

  localparam int deb_bits = $clog2(`PS2_DEBOUNCE_CYCLES + 1);

  // edge FSM, one pulse state per edge and a hold state behind it
  typedef enum logic [2:0] {
    edge_clk_h,
    edge_fall,
    edge_fall_wait,
    edge_clk_l,
    edge_rise,
    edge_rise_wait
  } edge_state_t;

  logic [1:0]          clk_sync;
  logic [1:0]          data_sync_q;
  logic [deb_bits-1:0] deb_count;
  logic                deb_done;
  edge_state_t         state;
  edge_state_t         state_next;

  // two flop synchronizers, the clock line idles high
  always_ff @(posedge clk)
  begin
    if (reset)
      clk_sync <= 2'b11;
    else
      clk_sync <= {clk_sync[0], ps2_clk};
    data_sync_q <= {data_sync_q[0], ps2_data};
  end

  assign data_sync = data_sync_q[1];

  // debounce counter restarts on every edge pulse and holds once done
  always_ff @(posedge clk)
  begin
    if (reset || fall_pulse || rise_pulse)
      deb_count <= '0;
    else if (!deb_done)
      deb_count <= deb_count + 1'b1;
  end

  assign deb_done = (deb_count == deb_bits'(`PS2_DEBOUNCE_CYCLES - 1));

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= edge_clk_h;
    else
      state <= state_next;
  end

  // changes on the line are ignored in the two wait states
  always_comb
  begin
    state_next = state;
    case (state)
      edge_clk_h:     if (!clk_sync[1]) state_next = edge_fall;
      edge_fall:      state_next = edge_fall_wait;
      edge_fall_wait: if (deb_done) state_next = edge_clk_l;
      edge_clk_l:     if (clk_sync[1]) state_next = edge_rise;
      edge_rise:      state_next = edge_rise_wait;
      edge_rise_wait: if (deb_done) state_next = edge_clk_h;
      default:        state_next = edge_clk_h;
    endcase
  end

  assign fall_pulse = (state == edge_fall);
  assign rise_pulse = (state == edge_rise);

endmodule

// File: ps2_mouse_xy.sv
// --------------------------------------
// ps/2 mouse top level
// receive only mouse front end with absolute cursor position
// --------------------------------------
`timescale 1ns/1ps

module ps2_mouse_xy (
  input  logic            clk,
  input  logic            reset,
  input  logic            ps2_clk,
  input  logic            ps2_data,
  output mouse_pkg::pos_t mx,
  output mouse_pkg::pos_t my,
  output logic [2:0]      btn_click,
  output logic            move
);

  logic fall_pulse;
  logic rise_pulse;
  logic data_sync;
  logic packet_good;

  // shifter to control and decoder
  rx_bits_if rx_bits ();

  // decoder to tracker
  report_if rep_bus ();

  ps2_line_filter u_filter (
    .clk        (clk),
    .reset      (reset),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .fall_pulse (fall_pulse),
    .rise_pulse (rise_pulse),
    .data_sync  (data_sync)
  );

  ps2_bit_shifter u_shifter (
    .clk        (clk),
    .reset      (reset),
    .fall_pulse (fall_pulse),
    .rise_pulse (rise_pulse),
    .data_sync  (data_sync),
    .rx         (rx_bits.shifter)
  );

  mouse_rx_control u_control (
    .clk         (clk),
    .reset       (reset),
    .fall_pulse  (fall_pulse),
    .packet_good (packet_good),
    .rx          (rx_bits.control)
  );

  mouse_packet_decoder u_decoder (
    .clk         (clk),
    .reset       (reset),
    .rx          (rx_bits.decoder),
    .packet_good (packet_good),
    .rep         (rep_bus.source)
  );

  cursor_tracker u_tracker (
    .clk       (clk),
    .reset     (reset),
    .rep       (rep_bus.sink),
    .mx        (mx),
    .my        (my),
    .btn_click (btn_click),
    .move      (move)
  );

endmodule

// File: tb_ps2_tasks.svh
// ----------------------------------------
// ps/2 bus model, output checks and directed tests
// ----------------------------------------
`ifndef TB_PS2_TASKS_SVH
`define TB_PS2_TASKS_SVH

// step n rising edges and land just after the last one
task automatic wait_cycles(input int n);
  repeat (n) @(posedge clk);
  #1;
endtask

// one frame with the start bit first and the data lsb first
// the device sets data while the clock is high, the host samples on the fall
task automatic send_frame(input logic [7:0] data, input logic bad_parity,
                          input logic bad_stop, input int nbits);
  logic [10:0] frame;
  frame = {!bad_stop, (~^data) ^ bad_parity, data, 1'b0};
  for (int i = 0; i < nbits; i++)
  begin
    ps2_data = frame[i];
    wait_cycles(half_period);
    ps2_clk = 1'b0;
    wait_cycles(half_period);
    ps2_clk = 1'b1;
  end
  ps2_data = 1'b1;
  wait_cycles(byte_gap);
endtask

// status, x and y frames, then the idle time that ends the packet
// a frame number of -1 means no fault, nbits below 33 cuts the packet short
task automatic send_packet(input logic [2:0] btn, input int dx, input int dy,
                           input int parity_frame, input int stop_frame, input int nbits);
  logic [7:0] frame_data [3];
  int         left_bits;
  int         n;
  // status byte is yv, xv, ys, xs, 1, m, r, l and the overflow bits stay 0
  frame_data[0] = {2'b00, dy[8], dx[8], 1'b1, btn[1], btn[0], btn[2]};
  frame_data[1] = dx[7:0];
  frame_data[2] = dy[7:0];
  left_bits = nbits;
  for (int f = 0; f < 3; f++)
  begin
    n = (left_bits > 11) ? 11 : left_bits;
    if (n > 0)
      send_frame(frame_data[f], parity_frame == f, stop_frame == f, n);
    left_bits -= n;
  end
  wait_cycles(packet_idle);
endtask

// the cursor stays inside 0..hi on each axis
function automatic int clamp(input int v, input int hi);
  if (v < 0)
    return 0;
  if (v > hi)
    return hi;
  return v;
endfunction

task automatic check_value(input string name, input string tag,
                           input logic [15:0] got, input logic [15:0] expected);
  checks++;
  if (got !== expected)
  begin
    errors++;
    $display("mismatch %s in %s: got 0x%h, expected 0x%h", name, tag, got, expected);
  end
endtask

task automatic check_outputs(input string tag);
  check_value("mx", tag, 16'(mx), 16'(exp_x));
  check_value("my", tag, 16'(my), 16'(exp_y));
  check_value("btn_click", tag, 16'(btn_click), 16'(exp_btn));
endtask

// a good packet gives exactly one move within the timeout from its last stop bit
// x adds the delta, y is inverted for the screen
task automatic send_good(input logic [2:0] btn, input int dx, input int dy,
                         input string tag);
  int start;
  int waited;
  start = move_count;
  send_packet(btn, dx, dy, -1, -1, 33);
  waited = packet_idle;
  while (move_count == start && waited < move_timeout)
  begin
    wait_cycles(1);
    waited++;
  end
  checks++;
  if (move_count != start + 1)
  begin
    errors++;
    $display("%s: expected one move pulse within %0d cycles, saw %0d",
             tag, move_timeout, move_count - start);
  end
  exp_x   = clamp(exp_x + dx, max_x);
  exp_y   = clamp(exp_y - dy, max_y);
  exp_btn = btn;
  check_outputs(tag);
endtask

// a rejected packet gives no move and changes nothing
task automatic send_bad(input int parity_frame, input int stop_frame, input int nbits,
                        input string tag);
  int start;
  start = move_count;
  send_packet(3'b101, 40, -40, parity_frame, stop_frame, nbits);
  wait_cycles(move_timeout - packet_idle);
  checks++;
  if (move_count != start)
  begin
    errors++;
    $display("%s: a packet that should be dropped still produced a move pulse", tag);
  end
  check_outputs(tag);
endtask

// ----------------------------------------
// directed tests
// ----------------------------------------

task automatic test_reset_state();
  check_outputs("reset");
  wait_cycles(50);
  checks++;
  if (move_count != 0)
  begin
    errors++;
    $display("move pulsed on an idle bus right after reset");
  end
  check_outputs("idle after reset");
endtask

task automatic test_tracking();
  int dx;
  int dy;
  send_good(3'b000, 200, -100, "track +x -y");
  send_good(3'b000, 150, -80, "track +x -y again");
  send_good(3'b000, -256, 40, "track dx -256");
  send_good(3'b000, -30, -255, "track -x -y");
  // random deltas cover -255..255 on both axes
  for (int i = 0; i < 6; i++)
  begin
    dx = $random(seed) % 256;
    dy = $random(seed) % 256;
    send_good(3'b000, dx, dy, "track random");
  end
endtask

task automatic test_clamping();
  repeat (4) send_good(3'b000, 255, 0, "clamp x high");
  check_value("mx", "x ceiling", 16'(mx), 16'(max_x));
  repeat (4) send_good(3'b000, -255, 0, "clamp x low");
  check_value("mx", "x floor", 16'(mx), 16'd0);
  // negative dy moves the cursor down the screen
  repeat (3) send_good(3'b000, 0, -255, "clamp y high");
  check_value("my", "y ceiling", 16'(my), 16'(max_y));
  repeat (2) send_good(3'b000, 0, 255, "clamp y low");
  check_value("my", "y floor", 16'(my), 16'd0);
endtask

// every combination of left, middle and right, ending with all released
task automatic test_buttons();
  for (int b = 1; b <= 8; b++)
    send_good(3'(b), 0, 0, "buttons");
endtask

task automatic test_bad_packets();
  send_bad(0, -1, 33, "bad parity in status frame");
  send_bad(1, -1, 33, "bad parity in x frame");
  send_bad(2, -1, 33, "bad parity in y frame");
  send_bad(-1, 1, 33, "stop bit low in x frame");
  send_bad(-1, 2, 33, "stop bit low in y frame");
  send_good(3'b010, 12, -7, "good packet after bad ones");
endtask

// 22 bits and then the idle gap, the next packet must land exactly once
task automatic test_truncated();
  int start;
  send_bad(-1, -1, 22, "truncated packet");
  start = move_count;
  send_good(3'b001, 25, 25, "full packet after truncated one");
  wait_cycles(packet_idle);
  checks++;
  if (move_count != start + 1)
  begin
    errors++;
    $display("the packet after a truncated one was applied %0d times", move_count - start);
  end
  check_outputs("settled after truncated");
endtask

`endif

// File: tb_ps2_mouse_xy.sv
// ----------------------------------------
// testbench for the ps/2 mouse front end
// directed packet tests against a position model
// ----------------------------------------
`timescale 1ns/1ps
`include "mouse_settings.svh"

module tb_ps2_mouse_xy;

  // bus model timing, all in clk cycles except the clock period
  localparam int clk_period   = 4;
  localparam int half_period  = 20;
  localparam int byte_gap     = 10;
  localparam int packet_idle  = 100;
  localparam int move_timeout = 200;
  localparam int max_x        = `MOUSE_MAX_X;
  localparam int max_y        = `MOUSE_MAX_Y;

  // one packet on the wire plus its wait for move
  // the tests send about 40 packets, the watchdog allows a few more
  localparam int packet_cycles   = 33 * 2 * half_period + 3 * byte_gap + move_timeout;
  localparam int packet_total    = 40;
  localparam longint watchdog_ns = longint'(packet_total + 5) * packet_cycles * clk_period;

  logic                       clk;
  logic                       reset;
  logic                       ps2_clk;
  logic                       ps2_data;
  logic [`MOUSE_POS_BITS-1:0] mx;
  logic [`MOUSE_POS_BITS-1:0] my;
  logic [2:0]                 btn_click;
  logic                       move;

  // reference position and buttons, in left-middle-right order
  int         exp_x;
  int         exp_y;
  logic [2:0] exp_btn;

  int     move_count = 0;
  int     errors = 0;
  int     checks = 0;
  integer seed;

  ps2_mouse_xy dut0 (
    .clk       (clk),
    .reset     (reset),
    .ps2_clk   (ps2_clk),
    .ps2_data  (ps2_data),
    .mx        (mx),
    .my        (my),
    .btn_click (btn_click),
    .move      (move)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // move is registered on the rising edge, so count it on the falling one
  always @(negedge clk)
  begin
    if (move === 1'b1)
      move_count++;
  end

  `include "tb_ps2_tasks.svh"

  // a stuck bus model or a lost pulse must not hang the run
  initial
  begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    reset    = 1'b1;
    ps2_clk  = 1'b1;
    ps2_data = 1'b1;
    exp_x    = 0;
    exp_y    = 0;
    exp_btn  = 3'b000;
    seed     = 40;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    test_reset_state();
    test_tracking();
    test_clamping();
    test_buttons();
    test_bad_packets();
    test_truncated();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
